// File: design/mul_arith_pkg.sv
`default_nettype none

// widths for the 64-bit multiply datapath
package mul_arith_pkg;

  // operand and result width
  localparam int xlen = 64;

  // one operand half, before sign extension
  localparam int half_w = xlen / 2;

  // half plus one sign bit, so every slice can be multiplied as signed
  localparam int slice_w = half_w + 1;

  // 33 x 33 partial product
  localparam int pp_w = 2 * slice_w;

  // full aligned sum; low 2*xlen bits hold the product
  localparam int sum_w = pp_w + xlen;

endpackage : mul_arith_pkg

`default_nettype wire

// File: design/mul_op_pkg.sv
`default_nettype none

// operations and control states of the multiply unit
package mul_op_pkg;

  // M-extension multiply ops, numbered like funct3
  typedef enum logic [2:0] {
    op_mul    = 3'd0,  // low 64 bits
    op_mulh   = 3'd1,  // high, signed x signed
    op_mulhsu = 3'd2,  // high, signed x unsigned
    op_mulhu  = 3'd3,  // high, unsigned x unsigned
    op_mulw   = 3'd4   // low word, sign-extended
  } mul_op_e;

  // occupancy of stage two
  typedef enum logic {
    st_empty = 1'b0,
    st_full  = 1'b1
  } stage_state_e;

  // which slice of the product goes out
  typedef enum logic [1:0] {
    sel_lo   = 2'd0,
    sel_hi   = 2'd1,
    sel_word = 2'd2
  } res_sel_e;

endpackage : mul_op_pkg

`default_nettype wire

// File: design/mul_pp_if.sv
`timescale 1ns/1ps
`default_nettype none

// stage-one to stage-two bundle
interface mul_pp_if;

  // registered partial products, lo/hi of multiplicand then multiplier
  logic [mul_arith_pkg::pp_w-1:0] ll;
  logic [mul_arith_pkg::pp_w-1:0] lh;
  logic [mul_arith_pkg::pp_w-1:0] hl;
  logic [mul_arith_pkg::pp_w-1:0] hh;

  // result select, registered with the products
  mul_op_pkg::res_sel_e res_sel;

  modport gen (
    output ll, lh, hl, hh
  );

  modport ctrl (
    output res_sel
  );

  modport sum (
    input ll, lh, hl, hh,
    input res_sel
  );

endinterface : mul_pp_if

`default_nettype wire

// File: design/mul_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mul_ctrl (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                in_valid,
  input  wire logic                flush,
  input  wire mul_op_pkg::mul_op_e op,
  output logic                     load,
  output logic                     src1_signed,
  output logic                     src2_signed,
  output logic                     out_valid,
  mul_pp_if.ctrl                   pp
);

  mul_op_pkg::stage_state_e stage_q;
  mul_op_pkg::res_sel_e     res_sel_d;

  // flush only kills the op issued this cycle
  assign load = in_valid & ~flush;

  // opcode decode
  always_comb begin
    src1_signed = 1'b0;
    src2_signed = 1'b0;
    res_sel_d   = mul_op_pkg::sel_lo;
    case (op)
      mul_op_pkg::op_mulh: begin
        src1_signed = 1'b1;
        src2_signed = 1'b1;
        res_sel_d   = mul_op_pkg::sel_hi;
      end
      mul_op_pkg::op_mulhsu: begin
        src1_signed = 1'b1;  // multiplier stays unsigned
        res_sel_d   = mul_op_pkg::sel_hi;
      end
      mul_op_pkg::op_mulhu: begin
        res_sel_d = mul_op_pkg::sel_hi;
      end
      mul_op_pkg::op_mulw: begin
        res_sel_d = mul_op_pkg::sel_word;  // sign of low word comes from the sum
      end
      default: begin
        res_sel_d = mul_op_pkg::sel_lo;  // plain mul
      end
    endcase
  end

  // stage two holds exactly one cycle, no stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q    <= mul_op_pkg::st_empty;
      pp.res_sel <= mul_op_pkg::sel_lo;
    end else begin
      stage_q <= load ? mul_op_pkg::st_full : mul_op_pkg::st_empty;
      if (load) begin
        pp.res_sel <= res_sel_d;  // travels with the partial products
      end
    end
  end

  assign out_valid = (stage_q == mul_op_pkg::st_full);

endmodule : mul_ctrl

`default_nettype wire

// File: design/mul_pp_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mul_pp_gen (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            load,
  input  wire logic                            src1_signed,
  input  wire logic                            src2_signed,
  input  wire logic [mul_arith_pkg::xlen-1:0]  multiplicand,
  input  wire logic [mul_arith_pkg::xlen-1:0]  multiplier,
  mul_pp_if.gen                                pp
);

  localparam int hw = mul_arith_pkg::half_w;
  localparam int xl = mul_arith_pkg::xlen;

  // 33-bit slices of each operand
  logic [mul_arith_pkg::slice_w-1:0] lo_src1;
  logic [mul_arith_pkg::slice_w-1:0] hi_src1;
  logic [mul_arith_pkg::slice_w-1:0] lo_src2;
  logic [mul_arith_pkg::slice_w-1:0] hi_src2;

  // unregistered partial products
  logic [mul_arith_pkg::pp_w-1:0] ll_d;
  logic [mul_arith_pkg::pp_w-1:0] lh_d;
  logic [mul_arith_pkg::pp_w-1:0] hl_d;
  logic [mul_arith_pkg::pp_w-1:0] hh_d;

  // low halves are always positive
  assign lo_src1 = {1'b0, multiplicand[hw-1:0]};
  assign lo_src2 = {1'b0, multiplier[hw-1:0]};

  // high halves carry the operand sign when the op treats it as signed
  assign hi_src1 = {src1_signed & multiplicand[xl-1], multiplicand[xl-1:hw]};
  assign hi_src2 = {src2_signed & multiplier[xl-1], multiplier[xl-1:hw]};

  // ll never negative, so unsigned is enough
  assign ll_d = lo_src1 * lo_src2;

  // remaining three in two's complement, widened to pp_w by context
  assign lh_d = $signed(lo_src1) * $signed(hi_src2);
  assign hl_d = $signed(hi_src1) * $signed(lo_src2);
  assign hh_d = $signed(hi_src1) * $signed(hi_src2);

  // stage register, written only by an accepted op
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp.ll <= '0;
      pp.lh <= '0;
      pp.hl <= '0;
      pp.hh <= '0;
    end else if (load) begin
      pp.ll <= ll_d;
      pp.lh <= lh_d;
      pp.hl <= hl_d;
      pp.hh <= hh_d;
    end
  end

endmodule : mul_pp_gen

`default_nettype wire

// File: design/mul_pp_sum.sv
`timescale 1ns/1ps
`default_nettype none

module mul_pp_sum (
  mul_pp_if.sum                              pp,
  output logic [mul_arith_pkg::xlen-1:0]     result
);

  localparam int hw = mul_arith_pkg::half_w;
  localparam int xl = mul_arith_pkg::xlen;
  localparam int pw = mul_arith_pkg::pp_w;
  localparam int sw = mul_arith_pkg::sum_w;

  // aligned terms
  logic [sw-1:0] ll_ext;
  logic [sw-1:0] lh_ext;
  logic [sw-1:0] hl_ext;
  logic [sw-1:0] hh_ext;
  logic [sw-1:0] prod;

  // weight 2^0
  assign ll_ext = {{(sw - pw){1'b0}}, pp.ll};

  // cross terms at weight 2^32, sign-extended to the top
  assign lh_ext = {{(sw - pw - hw){pp.lh[pw-1]}}, pp.lh, {hw{1'b0}}};
  assign hl_ext = {{(sw - pw - hw){pp.hl[pw-1]}}, pp.hl, {hw{1'b0}}};

  // weight 2^64, already fills the width
  assign hh_ext = {pp.hh, {xl{1'b0}}};

  // wraps mod 2^130; only the low 128 bits matter
  assign prod = ll_ext + lh_ext + hl_ext + hh_ext;

  always_comb begin
    case (pp.res_sel)
      mul_op_pkg::sel_hi:   result = prod[2*xl-1:xl];
      mul_op_pkg::sel_word: result = {{hw{prod[hw-1]}}, prod[hw-1:0]};  // mulw
      default:              result = prod[xl-1:0];
    endcase
  end

endmodule : mul_pp_sum

`default_nettype wire

// File: design/mul_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

// two-stage rv64 multiply: partial products, then align and sum
module mul_unit_top (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            in_valid,
  input  wire logic                            flush,
  input  wire mul_op_pkg::mul_op_e             op,
  input  wire logic [mul_arith_pkg::xlen-1:0]  multiplicand,
  input  wire logic [mul_arith_pkg::xlen-1:0]  multiplier,
  output logic                                 out_valid,
  output logic [mul_arith_pkg::xlen-1:0]       result
);

  logic load;
  logic src1_signed;
  logic src2_signed;

  // products and select between the stages
  mul_pp_if pp_bus ();

  mul_ctrl mul_ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .flush       (flush),
    .op          (op),
    .load        (load),
    .src1_signed (src1_signed),
    .src2_signed (src2_signed),
    .out_valid   (out_valid),
    .pp          (pp_bus.ctrl)
  );

  mul_pp_gen mul_pp_gen_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .load         (load),
    .src1_signed  (src1_signed),
    .src2_signed  (src2_signed),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .pp           (pp_bus.gen)
  );

  // stage two, combinational from the registers
  mul_pp_sum mul_pp_sum_i (
    .pp     (pp_bus.sum),
    .result (result)
  );

endmodule : mul_unit_top

`default_nettype wire

// File: bench/mul_unit_chk.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the control path of the multiply unit
module mul_unit_chk (
  input wire logic                     clk,
  input wire logic                     rst_n,
  input wire logic                     in_valid,
  input wire logic                     flush,
  input wire logic                     load,
  input wire logic                     out_valid,
  input wire mul_op_pkg::stage_state_e stage
);

  // no result leaves the unit during reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while in reset");

  accept_to_valid: assert property (
    @(posedge clk) disable iff (!rst_n) (in_valid && !flush) |=> out_valid
  ) else $error("accepted op gave no out_valid on the next cycle");

  flush_kills_issue: assert property (
    @(posedge clk) disable iff (!rst_n) flush |=> !out_valid
  ) else $error("op issued under flush still produced out_valid");

  load_not_flushed: assert property (@(posedge clk) disable iff (!rst_n) flush |-> !load)
    else $error("load strobe high together with flush");

  // idle or flushed issue leaves stage two empty
  stage_drains: assert property (
    @(posedge clk) disable iff (!rst_n)
      !(in_valid && !flush) |=> stage == mul_op_pkg::st_empty
  ) else $error("stage two still full after a cycle with no accepted op");

endmodule : mul_unit_chk

bind mul_unit_top mul_unit_chk mul_unit_chk_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .flush     (flush),
  .load      (load),
  .out_valid (out_valid),
  .stage     (mul_ctrl_i.stage_q)
);

`default_nettype wire

// File: bench/mul_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb;

  localparam int half_period   = 20;   // 40 ns clock
  localparam int reset_cycles  = 8;
  localparam int max_vectors   = 64;
  localparam int fields        = 6;    // words per stimulus line
  localparam int reset_timeout = 50;
  localparam int cycle_limit   = max_vectors + 4;

  logic                           clk;
  logic                           rst_n;
  logic                           in_valid;
  logic                           flush;
  mul_op_pkg::mul_op_e            op;
  logic [mul_arith_pkg::xlen-1:0] multiplicand;
  logic [mul_arith_pkg::xlen-1:0] multiplier;
  logic                           out_valid;
  logic [mul_arith_pkg::xlen-1:0] result;

  // op, multiplicand, multiplier, flush, expected valid, expected result
  logic [63:0] stim_mem [0:fields*max_vectors-1];
  int          n_vectors;

  mul_unit_top mul_unit_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .flush        (flush),
    .op           (op),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .out_valid    (out_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // inputs idle, reset held, then released on a falling edge
  initial begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    flush        = 1'b0;
    op           = mul_op_pkg::op_mul;
    multiplicand = '0;
    multiplier   = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic load_stimulus();
    int i;
    for (i = 0; i < fields * max_vectors; i++) begin
      stim_mem[i] = {32'hdead_beef, i[31:0]};  // op word above 4 marks the end
    end
    $readmemh("bench/mul_stim.txt", stim_mem);
    n_vectors = 0;
    while (n_vectors < max_vectors && stim_mem[fields*n_vectors] <= 64'd4) begin
      n_vectors++;
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < reset_timeout) begin
      @(posedge clk);  // rst_n only moves on falling edges
      n++;
    end
    assert (rst_n === 1'b1) else begin
      $display("reset was still asserted after %0d cycles", reset_timeout);
      abort_run();
    end
  endtask

  task automatic drive_vector(input int idx);
    int base;
    base         = fields * idx;
    in_valid     = 1'b1;
    op           = mul_op_pkg::mul_op_e'(stim_mem[base][2:0]);
    multiplicand = stim_mem[base+1];
    multiplier   = stim_mem[base+2];
    flush        = stim_mem[base+3][0];
  endtask

  task automatic drive_idle();
    in_valid = 1'b0;
    flush    = 1'b0;
  endtask

  // expectations of line idx show one cycle after it was issued
  task automatic check_outputs(input int idx);
    logic        exp_valid;
    logic [63:0] exp_result;
    exp_valid  = stim_mem[fields*idx+4][0];
    exp_result = stim_mem[fields*idx+5];
    assert (out_valid === exp_valid) else begin
      $display("error: time %0t out_valid expected %0b actual %0b",
               $time, exp_valid, out_valid);
      abort_run();
    end
    if (exp_valid) begin
      assert (result === exp_result) else begin
        $display("error: time %0t result expected %h actual %h",
                 $time, exp_result, result);
        abort_run();
      end
    end
  endtask

  initial begin
    int cycles;
    int i;
    cycles = 0;
    load_stimulus();
    wait_reset_release();
    @(negedge clk);
    if (n_vectors > 0) begin
      drive_vector(0);
    end
    for (i = 1; i <= n_vectors; i++) begin
      @(negedge clk);
      cycles++;
      assert (cycles <= cycle_limit) else begin
        $display("stimulus loop ran past %0d cycles", cycle_limit);
        abort_run();
      end
      if (i < n_vectors) begin
        drive_vector(i);  // a flush here must not hide the previous result
      end else begin
        drive_idle();
      end
      #1;  // outputs only move on rising edges
      check_outputs(i - 1);
    end

    // nothing issued, so the stage drains
    @(negedge clk);
    #1;
    assert (out_valid === 1'b0) else begin
      $display("error: time %0t out_valid expected 0 actual %0b", $time, out_valid);
      abort_run();
    end

    if (n_vectors > 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("no stimulus vectors were read from the data file");
      abort_run();
    end
  end

endmodule : mul_unit_tb

`default_nettype wire

// File: bench/mul_stim.txt
// op mcand mplier flush exp_valid exp_result (result shows the cycle after issue)
// op: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 mulw
0 0000000000000003 0000000000000005 0 1 000000000000000f
3 0000000000000003 0000000000000005 0 1 0000000000000000
0 ffffffffffffffff ffffffffffffffff 0 1 0000000000000001
3 ffffffffffffffff ffffffffffffffff 0 1 fffffffffffffffe
3 0000000100000000 0000000100000000 0 1 0000000000000001
0 123456789abcdef0 0000000000000010 0 1 23456789abcdef00
3 123456789abcdef0 0000000000000010 0 1 0000000000000001
0 ffffffffffffffff 0000000000000005 0 1 fffffffffffffffb
// signed high half
1 ffffffffffffffff ffffffffffffffff 0 1 0000000000000000
1 8000000000000000 8000000000000000 0 1 4000000000000000
1 fffffffffffffffe 0000000000000003 0 1 ffffffffffffffff
1 8000000000000000 7fffffffffffffff 0 1 c000000000000000
1 7fffffffffffffff 7fffffffffffffff 0 1 3fffffffffffffff
1 ffffffff00000000 0000000100000000 0 1 ffffffffffffffff
// only the multiplicand signed
2 ffffffffffffffff ffffffffffffffff 0 1 ffffffffffffffff
2 8000000000000000 8000000000000000 0 1 c000000000000000
2 0000000000000002 ffffffffffffffff 0 1 0000000000000001
// low word, sign-extended
4 0000000080000000 0000000000000001 0 1 ffffffff80000000
4 00000000ffffffff 00000000ffffffff 0 1 0000000000000001
4 abcdef0000010000 1234567800008000 0 1 ffffffff80000000
4 0000000000000007 0000000000000006 0 1 000000000000002a
// flush cancels only the op issued with it
0 0000000000000003 0000000000000005 1 0 0000000000000000
0 0000000000000007 0000000000000009 0 1 000000000000003f
0 0000000000000011 0000000000000011 1 0 0000000000000000
3 ffffffffffffffff 0000000000000002 1 0 0000000000000000
3 ffffffffffffffff 0000000000000002 0 1 0000000000000001
0 00000000deadbeef 0000000000000010 0 1 0000000deadbeef0

// File: sim.f
design/mul_arith_pkg.sv
design/mul_op_pkg.sv
design/mul_pp_if.sv
design/mul_ctrl.sv
design/mul_pp_gen.sv
design/mul_pp_sum.sv
design/mul_unit_top.sv
bench/mul_unit_chk.sv
bench/mul_unit_tb.sv

// File: Makefile
TOP := mul_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
